//--- rtl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Data path and register file geometry
////////////////////////////////////////////////////////////////////////////

// Width of operands, ALU result and bypass values
`define CPU_DATA_WIDTH 32

// GPR index width, 32 registers
`define CPU_REG_ADDR_WIDTH 5

////////////////////////////////////////////////////////////////////////////
// Hazard timing
////////////////////////////////////////////////////////////////////////////

// Tuse / Tnew counter width
`define CPU_TIME_WIDTH 3

// Tuse value for an operand that is never read
`define CPU_TUSE_IDLE 3'd7

// PC held by the pipeline registers out of reset
`define CPU_RESET_PC 32'h0000_3000

`endif

//--- rtl/cpuPkg.sv
package cpuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction classes reaching the execute end
	////////////////////////////////////////////////////////////////////////////

	// nop doubles as reset value and bubble
	typedef enum logic [3:0]
	{
		nop   = 4'd0,
		addu  = 4'd1,
		subu  = 4'd2,
		andOp = 4'd3,
		orOp  = 4'd4,
		ori   = 4'd5,
		slt   = 4'd6,
		sll   = 4'd7,
		lui   = 4'd8,
		lw    = 4'd9,
		sw    = 4'd10,
		jal   = 4'd11
	} instrType;

	// ALU function select
	typedef enum logic [2:0]
	{
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4,
		aluSll = 3'd5
	} aluOp;

	// Operand source at EX
	typedef enum logic [1:0]
	{
		fromReg = 2'd0,
		// EX/Mem register, one instruction ahead
		fromMem = 2'd1,
		// Mem/WB register, two ahead
		fromWb  = 2'd2
	} bypassSel;

endpackage

//--- rtl/aluOpDecoder.sv
`timescale 1ns/100ps

module aluOpDecoder
(
	input  cpuPkg::instrType instr,
	output cpuPkg::aluOp     op,
	output logic             useImm,
	output logic             useIdResult
);

	// ALU function per instruction class
	always_comb
	begin
		case (instr)
			cpuPkg::subu:
				op = cpuPkg::aluSub;
			cpuPkg::andOp:
				op = cpuPkg::aluAnd;
			cpuPkg::orOp,
			cpuPkg::ori:
				op = cpuPkg::aluOr;
			cpuPkg::slt:
				op = cpuPkg::aluSlt;
			cpuPkg::sll:
				op = cpuPkg::aluSll;
			// addu, and base + offset for lw / sw
			default:
				op = cpuPkg::aluAdd;
		endcase
	end

	// Second operand from imm32 instead of rt
	always_comb
	begin
		case (instr)
			cpuPkg::ori,
			cpuPkg::lw,
			cpuPkg::sw:
				useImm = 1'b1;
			default:
				useImm = 1'b0;
		endcase
	end

	// Result already formed in ID (upper imm, link address)
	assign useIdResult = (instr == cpuPkg::lui) || (instr == cpuPkg::jal);

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu
(
	input  logic [`CPU_DATA_WIDTH-1:0]     a,
	input  logic [`CPU_DATA_WIDTH-1:0]     b,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] shamt,
	input  cpuPkg::aluOp                   op,
	output logic [`CPU_DATA_WIDTH-1:0]     result
);

	// Signed compare result for slt
	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			cpuPkg::aluAdd:
				result = a + b;
			cpuPkg::aluSub:
				result = a - b;
			cpuPkg::aluAnd:
				result = a & b;
			cpuPkg::aluOr:
				result = a | b;
			// Zero extended flag
			cpuPkg::aluSlt:
				result = {{(`CPU_DATA_WIDTH-1){1'b0}}, lessThan};
			// Shift operand is rt, amount from the instruction
			cpuPkg::aluSll:
				result = b << shamt;
			default:
				result = '0;
		endcase
	end

endmodule

//--- rtl/execStage.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module execStage
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            stall,
	// Decode side
	input  cpuPkg::instrType                instr,
	input  logic [`CPU_DATA_WIDTH-1:0]      pc,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0]  rs,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0]  rt,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0]  rd,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0]  shamt,
	input  logic [`CPU_DATA_WIDTH-1:0]      imm32,
	input  logic [`CPU_DATA_WIDTH-1:0]      rsData,
	input  logic [`CPU_DATA_WIDTH-1:0]      rtData,
	input  logic [`CPU_DATA_WIDTH-1:0]      resultFromId,
	input  logic [`CPU_TIME_WIDTH-1:0]      tuseRs,
	input  logic [`CPU_TIME_WIDTH-1:0]      tuseRt,
	input  logic [`CPU_TIME_WIDTH-1:0]      tnewRd,
	// Forwarding
	input  cpuPkg::bypassSel                rsSel,
	input  cpuPkg::bypassSel                rtSel,
	input  logic [`CPU_DATA_WIDTH-1:0]      bypassMem,
	input  logic [`CPU_DATA_WIDTH-1:0]      bypassWb,
	// To hazard unit
	output logic [`CPU_REG_ADDR_WIDTH-1:0]  exRs,
	output logic [`CPU_REG_ADDR_WIDTH-1:0]  exRt,
	output logic [`CPU_TIME_WIDTH-1:0]      exTuseRs,
	output logic [`CPU_TIME_WIDTH-1:0]      exTuseRt,
	// EX/Mem register
	output cpuPkg::instrType                memInstr,
	output logic [`CPU_DATA_WIDTH-1:0]      memPc,
	output logic [`CPU_REG_ADDR_WIDTH-1:0]  memRd,
	output logic [`CPU_DATA_WIDTH-1:0]      memAluOut,
	output logic [`CPU_DATA_WIDTH-1:0]      memStoreData,
	output logic [`CPU_TIME_WIDTH-1:0]      memTnew
);

	cpuPkg::aluOp               op;
	logic                       useImm;
	logic                       useIdResult;
	logic [`CPU_DATA_WIDTH-1:0] rsFwd;
	logic [`CPU_DATA_WIDTH-1:0] rtFwd;
	logic [`CPU_DATA_WIDTH-1:0] aluB;
	logic [`CPU_DATA_WIDTH-1:0] aluRes;
	logic [`CPU_DATA_WIDTH-1:0] exResult;
	logic [`CPU_TIME_WIDTH-1:0] tnewDec;

	// One stage of countdown, stops at zero
	function automatic logic [`CPU_TIME_WIDTH-1:0] satDec
	(
		input logic [`CPU_TIME_WIDTH-1:0] t
	);
		return (t != '0) ? t - 1'b1 : t;
	endfunction

	// Operand source per hazard unit choice
	function automatic logic [`CPU_DATA_WIDTH-1:0] fwdMux
	(
		input cpuPkg::bypassSel           sel,
		input logic [`CPU_DATA_WIDTH-1:0] regVal,
		input logic [`CPU_DATA_WIDTH-1:0] memVal,
		input logic [`CPU_DATA_WIDTH-1:0] wbVal
	);
		case (sel)
			cpuPkg::fromMem: return memVal;
			cpuPkg::fromWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Hazard unit view of this stage
	////////////////////////////////////////////////////////////////////////////

	assign exRs     = rs;
	assign exRt     = rt;
	// Tuse counted relative to EX
	assign exTuseRs = satDec(tuseRs);
	assign exTuseRt = satDec(tuseRt);
	assign tnewDec  = satDec(tnewRd);

	////////////////////////////////////////////////////////////////////////////
	// Operand forwarding and ALU
	////////////////////////////////////////////////////////////////////////////

	assign rsFwd = fwdMux(rsSel, rsData, bypassMem, bypassWb);
	// Also the store data, so sw sees the newest rt
	assign rtFwd = fwdMux(rtSel, rtData, bypassMem, bypassWb);

	aluOpDecoder opDec0
	(
		.instr       (instr),
		.op          (op),
		.useImm      (useImm),
		.useIdResult (useIdResult)
	);

	assign aluB = useImm ? imm32 : rtFwd;

	alu alu0
	(
		.a      (rsFwd),
		.b      (aluB),
		.shamt  (shamt),
		.op     (op),
		.result (aluRes)
	);

	// lui and jal bypass the ALU
	assign exResult = useIdResult ? resultFromId : aluRes;

	////////////////////////////////////////////////////////////////////////////
	// EX/Mem register
	////////////////////////////////////////////////////////////////////////////

	// Control part, bubble while stalled
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			memInstr <= cpuPkg::nop;
			memPc    <= `CPU_RESET_PC;
			memRd    <= '0;
			memTnew  <= '0;
		end
		else if (stall)
		begin
			memInstr <= cpuPkg::nop;
			memPc    <= pc;
			memRd    <= '0;
			memTnew  <= '0;
		end
		else
		begin
			memInstr <= instr;
			memPc    <= pc;
			memRd    <= rd;
			memTnew  <= tnewDec;
		end
	end

	// Payload, meaningless under a bubble
	always_ff @(posedge clk)
	begin
		memAluOut    <= exResult;
		memStoreData <= rtFwd;
	end

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module hazardUnit
(
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] exRs,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] exRt,
	input  logic [`CPU_TIME_WIDTH-1:0]     exTuseRs,
	input  logic [`CPU_TIME_WIDTH-1:0]     exTuseRt,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] memRd,
	input  logic [`CPU_TIME_WIDTH-1:0]     memTnew,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] wbRd,
	input  logic [`CPU_TIME_WIDTH-1:0]     wbTnew,
	output cpuPkg::bypassSel               rsSel,
	output cpuPkg::bypassSel               rtSel,
	output logic                           stall
);

	logic rsMemHit;
	logic rsWbHit;
	logic rtMemHit;
	logic rtWbHit;
	logic rsStall;
	logic rtStall;

	// Producer writes the operand register; $0 never counts
	function automatic logic hits
	(
		input logic [`CPU_REG_ADDR_WIDTH-1:0] dst,
		input logic [`CPU_REG_ADDR_WIDTH-1:0] src
	);
		return (dst != '0) && (dst == src);
	endfunction

	// Mem first, WB only when Mem does not match
	function automatic cpuPkg::bypassSel pickSel
	(
		input logic                       memHit,
		input logic [`CPU_TIME_WIDTH-1:0] mTnew,
		input logic                       wbHit,
		input logic [`CPU_TIME_WIDTH-1:0] wTnew
	);
		if (memHit)
		begin
			if (mTnew == '0)
				return cpuPkg::fromMem;
			return cpuPkg::fromReg;
		end
		if (wbHit && (wTnew == '0))
			return cpuPkg::fromWb;
		return cpuPkg::fromReg;
	endfunction

	// Value still in flight but needed right now
	function automatic logic needStall
	(
		input logic                       memHit,
		input logic [`CPU_TIME_WIDTH-1:0] mTnew,
		input logic                       wbHit,
		input logic [`CPU_TIME_WIDTH-1:0] wTnew,
		input logic [`CPU_TIME_WIDTH-1:0] tuse
	);
		if (tuse != '0)
			return 1'b0;
		if (memHit)
			return mTnew != '0;
		return wbHit && (wTnew != '0);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Per operand match, select and stall
	////////////////////////////////////////////////////////////////////////////

	assign rsMemHit = hits(memRd, exRs);
	assign rsWbHit  = hits(wbRd, exRs);
	assign rtMemHit = hits(memRd, exRt);
	assign rtWbHit  = hits(wbRd, exRt);

	assign rsSel   = pickSel(rsMemHit, memTnew, rsWbHit, wbTnew);
	assign rtSel   = pickSel(rtMemHit, memTnew, rtWbHit, wbTnew);
	assign rsStall = needStall(rsMemHit, memTnew, rsWbHit, wbTnew, exTuseRs);
	assign rtStall = needStall(rtMemHit, memTnew, rtWbHit, wbTnew, exTuseRt);

	// Level, held as long as the producer is not ready
	assign stall = rsStall | rtStall;

endmodule

//--- rtl/memWbStage.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module memWbStage
(
	input  logic                           clk,
	input  logic                           reset,
	input  cpuPkg::instrType               memInstr,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] memRd,
	input  logic [`CPU_DATA_WIDTH-1:0]     memAluOut,
	input  logic [`CPU_TIME_WIDTH-1:0]     memTnew,
	// Load data from the data memory at Mem
	input  logic [`CPU_DATA_WIDTH-1:0]     dmReadData,
	output logic [`CPU_REG_ADDR_WIDTH-1:0] wbRd,
	output logic [`CPU_TIME_WIDTH-1:0]     wbTnew,
	output logic [`CPU_DATA_WIDTH-1:0]     wbValue,
	output logic [`CPU_DATA_WIDTH-1:0]     bypassMem,
	output logic [`CPU_DATA_WIDTH-1:0]     bypassWb
);

	logic [`CPU_DATA_WIDTH-1:0] memResult;
	logic [`CPU_TIME_WIDTH-1:0] tnewDec;

	// Loads take the memory word and all others the ALU result
	assign memResult = (memInstr == cpuPkg::lw) ? dmReadData : memAluOut;

	// Last countdown step where a lw reaches zero
	assign tnewDec = (memTnew != '0) ? memTnew - 1'b1 : memTnew;

	////////////////////////////////////////////////////////////////////////////
	// Mem/WB register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wbRd   <= '0;
			wbTnew <= '0;
		end
		else
		begin
			wbRd   <= memRd;
			wbTnew <= tnewDec;
		end
	end

	// Write-back value
	always_ff @(posedge clk)
	begin
		wbValue <= memResult;
	end

	// Forwarding taps
	// Mem tap carries only the ALU result since load data is not ready there
	assign bypassMem = memAluOut;
	assign bypassWb  = wbValue;

endmodule

//--- rtl/execSubsystem.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module execSubsystem
(
	input  logic                           clk,
	input  logic                           reset,
	input  cpuPkg::instrType               instr,
	input  logic [`CPU_DATA_WIDTH-1:0]     pc,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] rt,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] rd,
	input  logic [`CPU_REG_ADDR_WIDTH-1:0] shamt,
	input  logic [`CPU_DATA_WIDTH-1:0]     imm32,
	input  logic [`CPU_DATA_WIDTH-1:0]     rsData,
	input  logic [`CPU_DATA_WIDTH-1:0]     rtData,
	input  logic [`CPU_DATA_WIDTH-1:0]     resultFromId,
	input  logic [`CPU_TIME_WIDTH-1:0]     tuseRs,
	input  logic [`CPU_TIME_WIDTH-1:0]     tuseRt,
	input  logic [`CPU_TIME_WIDTH-1:0]     tnewRd,
	input  logic [`CPU_DATA_WIDTH-1:0]     dmReadData,
	output logic                           stall,
	output logic [`CPU_DATA_WIDTH-1:0]     memPc,
	output cpuPkg::instrType               memInstr,
	output logic [`CPU_DATA_WIDTH-1:0]     memAluOut,
	output logic [`CPU_DATA_WIDTH-1:0]     memStoreData,
	output logic [`CPU_REG_ADDR_WIDTH-1:0] wbRd,
	output logic [`CPU_DATA_WIDTH-1:0]     wbValue
);

	// EX to hazard unit
	logic [`CPU_REG_ADDR_WIDTH-1:0] exRs;
	logic [`CPU_REG_ADDR_WIDTH-1:0] exRt;
	logic [`CPU_TIME_WIDTH-1:0]     exTuseRs;
	logic [`CPU_TIME_WIDTH-1:0]     exTuseRt;
	// Producers
	logic [`CPU_REG_ADDR_WIDTH-1:0] memRd;
	logic [`CPU_TIME_WIDTH-1:0]     memTnew;
	logic [`CPU_TIME_WIDTH-1:0]     wbTnew;
	// Forwarding paths
	logic [`CPU_DATA_WIDTH-1:0]     bypassMem;
	logic [`CPU_DATA_WIDTH-1:0]     bypassWb;
	cpuPkg::bypassSel               rsSel;
	cpuPkg::bypassSel               rtSel;

	execStage ex0
	(
		.clk          (clk),
		.reset        (reset),
		.stall        (stall),
		.instr        (instr),
		.pc           (pc),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.shamt        (shamt),
		.imm32        (imm32),
		.rsData       (rsData),
		.rtData       (rtData),
		.resultFromId (resultFromId),
		.tuseRs       (tuseRs),
		.tuseRt       (tuseRt),
		.tnewRd       (tnewRd),
		.rsSel        (rsSel),
		.rtSel        (rtSel),
		.bypassMem    (bypassMem),
		.bypassWb     (bypassWb),
		.exRs         (exRs),
		.exRt         (exRt),
		.exTuseRs     (exTuseRs),
		.exTuseRt     (exTuseRt),
		.memInstr     (memInstr),
		.memPc        (memPc),
		.memRd        (memRd),
		.memAluOut    (memAluOut),
		.memStoreData (memStoreData),
		.memTnew      (memTnew)
	);

	hazardUnit hz0
	(
		.exRs     (exRs),
		.exRt     (exRt),
		.exTuseRs (exTuseRs),
		.exTuseRt (exTuseRt),
		.memRd    (memRd),
		.memTnew  (memTnew),
		.wbRd     (wbRd),
		.wbTnew   (wbTnew),
		.rsSel    (rsSel),
		.rtSel    (rtSel),
		.stall    (stall)
	);

	memWbStage mw0
	(
		.clk        (clk),
		.reset      (reset),
		.memInstr   (memInstr),
		.memRd      (memRd),
		.memAluOut  (memAluOut),
		.memTnew    (memTnew),
		.dmReadData (dmReadData),
		.wbRd       (wbRd),
		.wbTnew     (wbTnew),
		.wbValue    (wbValue),
		.bypassMem  (bypassMem),
		.bypassWb   (bypassWb)
	);

endmodule

//--- tb/execTests.svh
`ifndef EXEC_TESTS_SVH
`define EXEC_TESTS_SVH

// Two nops clear any earlier producer out of Mem and WB
task automatic flushPipe();
	int stalls;
	repeat (2)
	begin
		drive(cpuPkg::nop, '0, '0, '0, '0, '0);
		advance(stalls);
	end
endtask

// Checked before any edge after reset has loaded the registers
task automatic resetStateTest();
	int errorsBefore;
	errorsBefore = errorCount;
	checkEq("stall after reset", 32'(stall), 32'd0);
	checkEq("memInstr after reset", 32'(memInstr), 32'(cpuPkg::nop));
	checkEq("memPc after reset", memPc, `CPU_RESET_PC);
	checkEq("wbRd after reset", 32'(wbRd), 32'd0);
	reportTest("reset state", errorsBefore);
endtask

// Sources in 1..15 and destinations in 16..31 keep every operand off the bypass
task automatic aluOpsTest();
	int                             errorsBefore;
	int                             stalls;
	cpuPkg::instrType               i;
	logic [`CPU_REG_ADDR_WIDTH-1:0] d;
	logic [`CPU_DATA_WIDTH-1:0]     dmWord;
	logic [`CPU_DATA_WIDTH-1:0]     exp;
	logic [`CPU_DATA_WIDTH-1:0]     prevExp;
	errorsBefore = errorCount;
	flushPipe();
	dmWord     = $urandom();
	dmReadData = dmWord;
	prevExp    = '0;
	i          = cpuPkg::addu;
	repeat (11)
	begin
		d = (i == cpuPkg::sw) ? 5'd0 : 5'($urandom_range(16, 31));
		drive(i, 5'($urandom_range(1, 15)), 5'($urandom_range(1, 15)), d,
			$urandom(), $urandom());
		advance(stalls);
		exp = modelResult(i, rsData, rtData);
		checkEq($sformatf("stall cycles for %s", i.name()), stalls, 0);
		checkEq($sformatf("memInstr for %s", i.name()), 32'(memInstr), 32'(i));
		checkEq($sformatf("memPc for %s", i.name()), memPc, pc);
		checkEq($sformatf("memAluOut for %s", i.name()), memAluOut, exp);
		if (i == cpuPkg::sw)
			checkEq("memStoreData for sw", memStoreData, rtData);
		// Older instruction has just reached WB
		if (i != cpuPkg::addu)
			checkEq($sformatf("wbValue ahead of %s", i.name()), wbValue, prevExp);
		prevExp = (i == cpuPkg::lw) ? dmWord : exp;
		i = i.next();
	end
	reportTest("ALU instructions", errorsBefore);
endtask

task automatic forwardTest();
	int                         errorsBefore;
	int                         stalls;
	logic [`CPU_DATA_WIDTH-1:0] first;
	logic [`CPU_DATA_WIDTH-1:0] second;
	errorsBefore = errorCount;
	flushPipe();
	// Back to back pair with rs taken from Mem
	drive(cpuPkg::addu, 5'd1, 5'd2, 5'd5, $urandom(), $urandom());
	advance(stalls);
	first = modelResult(cpuPkg::addu, rsData, rtData);
	drive(cpuPkg::subu, 5'd5, 5'd3, 5'd4, $urandom(), $urandom());
	advance(stalls);
	checkEq("stall cycles, Mem forward", stalls, 0);
	checkEq("subu with rs from Mem", memAluOut, modelResult(cpuPkg::subu, first, rtData));
	// One nop between the pair so rt comes from WB
	drive(cpuPkg::orOp, 5'd1, 5'd2, 5'd6, $urandom(), $urandom());
	advance(stalls);
	first = modelResult(cpuPkg::orOp, rsData, rtData);
	drive(cpuPkg::nop, '0, '0, '0, '0, '0);
	advance(stalls);
	drive(cpuPkg::subu, 5'd3, 5'd6, 5'd4, $urandom(), $urandom());
	advance(stalls);
	checkEq("stall cycles, WB forward", stalls, 0);
	checkEq("subu with rt from WB", memAluOut, modelResult(cpuPkg::subu, rsData, first));
	// With r7 in both Mem and WB the younger value wins
	drive(cpuPkg::addu, 5'd1, 5'd2, 5'd7, $urandom(), $urandom());
	advance(stalls);
	drive(cpuPkg::andOp, 5'd3, 5'd8, 5'd7, $urandom(), $urandom());
	advance(stalls);
	second = modelResult(cpuPkg::andOp, rsData, rtData);
	drive(cpuPkg::addu, 5'd7, 5'd7, 5'd9, $urandom(), $urandom());
	advance(stalls);
	checkEq("addu with r7 in Mem and WB", memAluOut, modelResult(cpuPkg::addu, second, second));
	reportTest("forwarding", errorsBefore);
endtask

task automatic loadUseTest();
	int                         errorsBefore;
	int                         stalls;
	logic [`CPU_DATA_WIDTH-1:0] loadWord;
	errorsBefore = errorCount;
	flushPipe();
	drive(cpuPkg::lw, 5'd11, 5'd0, 5'd10, $urandom(), 32'd0);
	advance(stalls);
	checkEq("lw address", memAluOut, modelResult(cpuPkg::lw, rsData, rtData));
	// Memory answers while the lw sits at Mem
	loadWord   = $urandom();
	dmReadData = loadWord;
	drive(cpuPkg::addu, 5'd10, 5'd12, 5'd13, $urandom(), $urandom());
	waitStallLow(stalls);
	checkTrue(stalls >= 1, "load-use raised no stall");
	// Released with the load in WB
	checkEq("wbRd of lw", 32'(wbRd), 32'd10);
	checkEq("wbValue of lw", wbValue, loadWord);
	@(negedge clk);
	checkEq("stall after load-use", 32'(stall), 32'd0);
	checkEq("addu with loaded rs", memAluOut, modelResult(cpuPkg::addu, loadWord, rtData));
	reportTest("load-use", errorsBefore);
endtask

task automatic zeroRegTest();
	int errorsBefore;
	int stalls;
	errorsBefore = errorCount;
	flushPipe();
	// ALU write to $0 right ahead of a reader
	drive(cpuPkg::addu, 5'd1, 5'd2, 5'd0, $urandom(), $urandom());
	advance(stalls);
	drive(cpuPkg::addu, 5'd0, 5'd14, 5'd15, 32'd0, $urandom());
	advance(stalls);
	checkEq("stall cycles behind $0 writer", stalls, 0);
	checkEq("addu reading $0", memAluOut, modelResult(cpuPkg::addu, 32'd0, rtData));
	// Load to $0 with a Tuse 0 reader
	drive(cpuPkg::lw, 5'd1, 5'd0, 5'd0, $urandom(), 32'd0);
	advance(stalls);
	drive(cpuPkg::subu, 5'd0, 5'd0, 5'd16, 32'd0, 32'd0);
	advance(stalls);
	checkEq("stall cycles behind lw to $0", stalls, 0);
	checkEq("subu reading $0", memAluOut, 32'd0);
	reportTest("register zero", errorsBefore);
endtask

`endif

//--- tb/execSubsystemTb.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module execSubsystemTb;

	// Cycles a held instruction may wait on stall
	localparam int stallLimit = 16;

	logic                           clk;
	logic                           reset;
	// Decode side stimulus
	cpuPkg::instrType               instr;
	logic [`CPU_DATA_WIDTH-1:0]     pc;
	logic [`CPU_REG_ADDR_WIDTH-1:0] rs;
	logic [`CPU_REG_ADDR_WIDTH-1:0] rt;
	logic [`CPU_REG_ADDR_WIDTH-1:0] rd;
	logic [`CPU_REG_ADDR_WIDTH-1:0] shamt;
	logic [`CPU_DATA_WIDTH-1:0]     imm32;
	logic [`CPU_DATA_WIDTH-1:0]     rsData;
	logic [`CPU_DATA_WIDTH-1:0]     rtData;
	logic [`CPU_DATA_WIDTH-1:0]     resultFromId;
	logic [`CPU_TIME_WIDTH-1:0]     tuseRs;
	logic [`CPU_TIME_WIDTH-1:0]     tuseRt;
	logic [`CPU_TIME_WIDTH-1:0]     tnewRd;
	// Data memory side
	logic [`CPU_DATA_WIDTH-1:0]     dmReadData;
	// DUT responses
	logic                           stall;
	logic [`CPU_DATA_WIDTH-1:0]     memPc;
	cpuPkg::instrType               memInstr;
	logic [`CPU_DATA_WIDTH-1:0]     memAluOut;
	logic [`CPU_DATA_WIDTH-1:0]     memStoreData;
	logic [`CPU_REG_ADDR_WIDTH-1:0] wbRd;
	logic [`CPU_DATA_WIDTH-1:0]     wbValue;

	int checkCount;
	int errorCount;
	int testCount;
	int failedTests;

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	execSubsystem dut0
	(
		.clk          (clk),
		.reset        (reset),
		.instr        (instr),
		.pc           (pc),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.shamt        (shamt),
		.imm32        (imm32),
		.rsData       (rsData),
		.rtData       (rtData),
		.resultFromId (resultFromId),
		.tuseRs       (tuseRs),
		.tuseRt       (tuseRt),
		.tnewRd       (tnewRd),
		.dmReadData   (dmReadData),
		.stall        (stall),
		.memPc        (memPc),
		.memInstr     (memInstr),
		.memAluOut    (memAluOut),
		.memStoreData (memStoreData),
		.wbRd         (wbRd),
		.wbValue      (wbValue)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checkers
	////////////////////////////////////////////////////////////////////////////

	// Expected EX result, a and b are the operand values after forwarding
	function automatic logic [`CPU_DATA_WIDTH-1:0] modelResult
	(
		input cpuPkg::instrType           i,
		input logic [`CPU_DATA_WIDTH-1:0] a,
		input logic [`CPU_DATA_WIDTH-1:0] b
	);
		case (i)
			cpuPkg::addu:  return a + b;
			cpuPkg::subu:  return a - b;
			cpuPkg::andOp: return a & b;
			cpuPkg::orOp:  return a | b;
			cpuPkg::ori:   return a | imm32;
			// Signed compare
			cpuPkg::slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			cpuPkg::sll:   return b << shamt;
			// Address is base plus offset
			cpuPkg::lw,
			cpuPkg::sw:    return a + imm32;
			cpuPkg::lui,
			cpuPkg::jal:   return resultFromId;
			default:       return 32'd0;
		endcase
	endfunction

	task automatic checkEq
	(
		input string                      what,
		input logic [`CPU_DATA_WIDTH-1:0] got,
		input logic [`CPU_DATA_WIDTH-1:0] exp
	);
		checkCount++;
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checkCount++;
		assert (cond)
		else
		begin
			errorCount++;
			$display("** Error at %0t: %s", $time, what);
		end
	endtask

	// Bounded wait for the hazard unit to release the held instruction
	task automatic waitStallLow(output int stalls);
		int n;
		n = 0;
		#1;
		while (stall && (n < stallLimit))
		begin
			@(negedge clk);
			#1;
			n++;
		end
		if (stall)
		begin
			errorCount++;
			$display("Timeout at %0t: stall still high after %0d cycles", $time, n);
		end
		stalls = n;
	endtask

	// Instruction accepted, EX/Mem now holds it
	task automatic advance(output int stalls);
		waitStallLow(stalls);
		@(negedge clk);
	endtask

	// Decode stage stand-in, Tuse and Tnew follow the instruction class
	task automatic drive
	(
		input cpuPkg::instrType               i,
		input logic [`CPU_REG_ADDR_WIDTH-1:0] rsIdx,
		input logic [`CPU_REG_ADDR_WIDTH-1:0] rtIdx,
		input logic [`CPU_REG_ADDR_WIDTH-1:0] rdIdx,
		input logic [`CPU_DATA_WIDTH-1:0]     rsVal,
		input logic [`CPU_DATA_WIDTH-1:0]     rtVal
	);
		instr        = i;
		pc           = pc + 32'd4;
		rs           = rsIdx;
		rt           = rtIdx;
		rd           = rdIdx;
		rsData       = rsVal;
		rtData       = rtVal;
		shamt        = 5'($urandom_range(0, 31));
		imm32        = $urandom();
		resultFromId = $urandom();
		tuseRs       = `CPU_TUSE_IDLE;
		tuseRt       = `CPU_TUSE_IDLE;
		tnewRd       = 3'd1;
		case (i)
			cpuPkg::addu,
			cpuPkg::subu,
			cpuPkg::andOp,
			cpuPkg::orOp,
			cpuPkg::slt:
			begin
				tuseRs = 3'd1;
				tuseRt = 3'd1;
			end
			cpuPkg::ori:
				tuseRs = 3'd1;
			cpuPkg::lw:
			begin
				tuseRs = 3'd1;
				tnewRd = 3'd2;
			end
			// Store data needed one stage later
			cpuPkg::sw:
			begin
				tuseRs = 3'd1;
				tuseRt = 3'd2;
				tnewRd = 3'd0;
			end
			cpuPkg::sll:
				tuseRt = 3'd1;
			cpuPkg::nop:
				tnewRd = 3'd0;
			default:
				tnewRd = 3'd1;
		endcase
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("[%0t] %s: ok", $time, name);
		else
		begin
			failedTests++;
			$display("[%0t] %s: FAILED, %0d errors", $time, name, errorCount - errorsBefore);
		end
	endtask

	`include "execTests.svh"

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h11f2_f81c));
		checkCount   = 0;
		errorCount   = 0;
		testCount    = 0;
		failedTests  = 0;
		reset        = 1'b1;
		instr        = cpuPkg::nop;
		pc           = `CPU_RESET_PC;
		rs           = '0;
		rt           = '0;
		rd           = '0;
		shamt        = '0;
		imm32        = '0;
		rsData       = '0;
		rtData       = '0;
		resultFromId = '0;
		tuseRs       = `CPU_TUSE_IDLE;
		tuseRt       = `CPU_TUSE_IDLE;
		tnewRd       = '0;
		dmReadData   = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		resetStateTest();
		aluOpsTest();
		forwardTest();
		loadUseTest();
		zeroRegTest();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+rtl
+incdir+tb
rtl/cpuPkg.sv
rtl/aluOpDecoder.sv
rtl/alu.sv
rtl/execStage.sv
rtl/hazardUnit.sv
rtl/memWbStage.sv
rtl/execSubsystem.sv
tb/execSubsystemTb.sv

//--- Makefile
# Verilator build and run of the execute subsystem testbench

VERILATOR ?= verilator
TOP       ?= execSubsystemTb
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --assert --timescale 1ns/100ps
PASS_MSG  ?= Simulation passed

SRCS := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv tb/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
